// ==== Bender.yml ====
package:
  name: sprite_video

sources:
  - verilog/sprite_pkg.sv
  - verilog/beam_if.sv
  - verilog/video_timing.sv
  - verilog/sprite_table.sv
  - verilog/sprite_shape_rom.sv
  - verilog/sprite_line_renderer.sv
  - verilog/playfield_gen.sv
  - verilog/pixel_mixer.sv
  - verilog/sprite_video_top.sv
  - target: test
    files:
      - dv/sprite_video_tb.sv

// ==== dv/sprite_video_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_video_tb
  import sprite_pkg::*;
();

  localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
  localparam int ACK_TIMEOUT  = 300; // well past the 72 clock load window

  logic        clk;
  logic        reset;
  logic        host_req;
  logic [5:0]  host_addr;
  logic [15:0] host_wdata;
  logic        host_ack;
  logic [3:0]  rgb;
  logic        hsync;
  logic        vsync;

  // beam position from the timing rules, pix_* is the one rgb shows (2 clocks back)
  int beam_h;
  int beam_v;
  int d1_h;
  int d1_v;
  int pix_h;
  int pix_v;

  // sprite table as the host wrote it
  logic [7:0] m_xpos  [SPRITE_COUNT];
  logic [7:0] m_ypos  [SPRITE_COUNT];
  logic [1:0] m_shape [SPRITE_COUNT];
  color_t     m_color [SPRITE_COUNT];
  logic [9:0] m_resv  [SPRITE_COUNT];
  color_t     sprite_line [256]; // expected sprite pixels of the current line

  int          errors;
  int          checks;
  int          test_errors;
  int          tests_run;
  bit          timed_out;
  int unsigned seed_init;

  sprite_video_top sprite_video_top_inst (
    .clk        (clk),
    .reset      (reset),
    .host_req   (host_req),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .rgb        (rgb),
    .hsync      (hsync),
    .vsync      (vsync)
  );

  always #10 clk = ~clk; // 20 ns

  always @(posedge clk) begin
    if (reset) begin
      beam_h <= 0;
      beam_v <= 0;
      d1_h   <= 0;
      d1_v   <= 0;
      pix_h  <= 0;
      pix_v  <= 0;
    end else begin
      beam_h <= (beam_h == H_TOTAL - 1) ? 0 : beam_h + 1;
      if (beam_h == H_TOTAL - 1)
        beam_v <= (beam_v == V_TOTAL - 1) ? 0 : beam_v + 1;
      d1_h  <= beam_h; // two stage pipe, same as the pixel latency
      d1_v  <= beam_v;
      pix_h <= d1_h;
      pix_v <= d1_v;
    end
  end

  task automatic step();
    @(posedge clk);
    #1; // drive and sample here, outputs settled
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      test_errors++;
      $display("[FAIL] %0t ns: %s: got %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    test_errors++;
    timed_out = 1;
  endtask

  task automatic wait_beam(input int v, input int h);
    int n;
    n = 0;
    while (!timed_out && !(beam_v == v && beam_h == h)) begin
      step();
      n++;
      if (n > FRAME_CYCLES + 10)
        note_timeout("a beam position");
    end
  endtask

  task automatic wait_pixel(input int v, input int h);
    int n;
    n = 0;
    while (!timed_out && !(pix_v == v && pix_h == h)) begin
      step();
      n++;
      if (n > FRAME_CYCLES + 10)
        note_timeout("a pixel position on rgb");
    end
  endtask

  // one four-phase write, ack may be held off by the load window
  task automatic write_word(input logic [5:0] addr, input logic [15:0] data);
    int n;
    host_addr  = addr;
    host_wdata = data;
    host_req   = 1'b1;
    n = 0;
    while (!timed_out && !host_ack) begin
      step();
      n++;
      if (n > ACK_TIMEOUT)
        note_timeout("host_ack to rise");
    end
    host_req = 1'b0;
    n = 0;
    while (!timed_out && host_ack) begin
      step();
      n++;
      if (n > 4)
        note_timeout("host_ack to fall");
    end
    step();
  endtask

  task automatic write_table();
    int i;
    for (i = 0; i < SPRITE_COUNT; i++) begin
      write_word({5'(i), 1'b0}, {m_ypos[i], m_xpos[i]});
      write_word({5'(i), 1'b1}, {m_resv[i], m_shape[i], m_color[i]});
    end
  endtask

  // ypos 250 and up is only selected on lines that are never shown
  task automatic hide_all();
    int i;
    for (i = 0; i < SPRITE_COUNT; i++) begin
      m_xpos[i]  = 8'($urandom);
      m_ypos[i]  = 8'(250 + $urandom % 6);
      m_shape[i] = 2'($urandom);
      m_color[i] = 4'(1 + $urandom % 15);
      m_resv[i]  = 10'($urandom); // ignored by the renderer
    end
  endtask

  task automatic place_sprite(input int i, input int x, input int y);
    m_xpos[i]  = 8'(x);
    m_ypos[i]  = 8'(y);
    m_shape[i] = 2'($urandom);
    m_color[i] = 4'(1 + $urandom % 15);
  endtask

  // bit 0 is the leftmost pixel
  function automatic logic [15:0] shape_row(input logic [1:0] shape, input logic [3:0] row);
    logic [15:0] fig [16];
    fig = '{16'h07e0, 16'h1ff8, 16'h3ffc, 16'h799e, 16'h799e, 16'h7ffe, 16'h7ffe, 16'h6ff6,
            16'h77ee, 16'h3c3c, 16'h1ff8, 16'h07e0, 16'h0180, 16'h0ff0, 16'h0990, 16'h1818};
    case (shape)
      2'd0: return fig[row];
      2'd1: return 16'hffff;
      2'd2: return (row == 0 || row == 15) ? 16'hffff : 16'h8001;
      default: return 16'h0001 << row;
    endcase
  endfunction

  // display line L shows the sprites selected on line L-1
  task automatic build_line(input int line);
    int i;
    int x;
    int col;
    int taken;
    int yofs;
    logic [15:0] bits;
    for (i = 0; i < 256; i++)
      sprite_line[i] = 4'd0;
    if (line == 0 || line > 256)
      return; // the line before is never drawn
    taken = 0;
    for (i = 0; i < SPRITE_COUNT; i++) begin
      yofs = line - 1 - int'(m_ypos[i]);
      if (yofs >= 0 && yofs < SPRITE_SIZE && taken < SLOT_COUNT) begin
        taken++; // lowest index first, later slot paints on top
        bits = shape_row(m_shape[i], 4'(yofs));
        for (x = 0; x < SPRITE_SIZE; x++) begin
          col = m_xpos[i] + x;
          if (bits[x] && col < 256)
            sprite_line[col] = m_color[i];
        end
      end
    end
  endtask

  function automatic logic [3:0] expected_rgb(input int h, input int v);
    if (h >= H_DISPLAY || v >= V_DISPLAY)
      return 4'd0; // blanking
    if (sprite_line[h] != 0)
      return sprite_line[h];
    return (h % 32 == 0 || v % 32 == 0) ? GRID_COLOR : FIELD_COLOR;
  endfunction

  task automatic check_frame();
    int n;
    wait_pixel(0, 0);
    for (n = 0; n < FRAME_CYCLES && !timed_out && test_errors < 20; n++) begin
      if (pix_h == 0)
        build_line(pix_v);
      check_value($sformatf("rgb at x=%0d y=%0d", pix_h, pix_v), rgb,
                  expected_rgb(pix_h, pix_v));
      step();
    end
  endtask

  // write the table, let it be copied on the load line, check the next frame
  task automatic load_and_check();
    write_table();
    wait_beam(LOAD_LINE, 0);
    check_frame();
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("%-16s %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
  endtask

  task automatic single_sprites_test();
    test_errors = 0;
    hide_all();
    place_sprite(3, $urandom % 40, $urandom % 200);
    place_sprite(9, 64 + $urandom % 40, $urandom % 200);
    place_sprite(17, 128 + $urandom % 40, 224 + $urandom % 15); // cut at the bottom
    place_sprite(28, 245 + $urandom % 11, $urandom % 200);      // cut at the right
    load_and_check();
    report_test("single sprites");
  endtask

  task automatic overlap_test();
    int i;
    int cx;
    int cy;
    test_errors = 0;
    hide_all();
    cx = 40 + $urandom % 150;
    cy = 20 + $urandom % 150;
    for (i = 0; i < 6; i++)
      place_sprite(i, cx + $urandom % 9, cy + $urandom % 9);
    place_sprite(12, 10 + $urandom % 20, 30 + $urandom % 20);
    place_sprite(13, 14 + $urandom % 20, 34 + $urandom % 20);
    load_and_check();
    report_test("overlap");
  endtask

  task automatic slot_limit_test();
    int i;
    int base;
    test_errors = 0;
    hide_all();
    base = 20 + $urandom % 100;
    for (i = 0; i < 12; i++)
      place_sprite(i, $urandom % 240, base + $urandom % 3);      // 12 on one band
    for (i = 16; i < 22; i++)
      place_sprite(i, $urandom % 240, base + 80 + $urandom % 3); // 6, all fit
    load_and_check();
    report_test("slot limit");
  endtask

  task automatic playfield_test();
    test_errors = 0;
    hide_all();
    load_and_check();
    report_test("playfield");
  endtask

  task automatic handshake_test();
    int n;
    logic [7:0] new_x;
    logic [7:0] new_y;
    test_errors = 0;
    hide_all();
    place_sprite(5, 30 + $urandom % 60, 40 + $urandom % 100);
    write_table();
    check_value("host_ack idle", host_ack, 1'b0);
    new_x = 8'(120 + $urandom % 100);
    new_y = 8'(20 + $urandom % 180);
    wait_beam(LOAD_LINE, 2);  // inside the load window
    host_addr  = 6'd0;
    host_wdata = {new_y, new_x};
    host_req   = 1'b1;
    n = 0;
    while (!timed_out && !host_ack) begin
      step();
      n++;
      if (n > ACK_TIMEOUT)
        note_timeout("host_ack during the load line");
    end
    check_value("line when host_ack rises", beam_v, LOAD_LINE);
    check_value("hpos when host_ack rises", beam_h, LOAD_CYCLES + 1);
    repeat (3) begin
      step();
      check_value("host_ack while host_req high", host_ack, 1'b1);
    end
    host_req = 1'b0;
    step();
    check_value("host_ack after host_req drops", host_ack, 1'b0);
    check_frame();            // this frame was copied before the write
    m_xpos[0] = new_x;
    m_ypos[0] = new_y;
    wait_beam(LOAD_LINE, 0);
    check_frame();
    report_test("handshake");
  endtask

  task automatic measure_period(input bit use_vsync, output int period);
    int   n;
    int   rises;
    logic prev;
    logic cur;
    period = 0;
    rises  = 0;
    n      = 0;
    prev   = 1'b1; // skip a pulse that is already high
    while (!timed_out && rises < 2) begin
      step();
      n++;
      cur = use_vsync ? vsync : hsync;
      if (cur && !prev) begin
        if (rises == 1)
          period = n;
        rises++;
        n = 0;
      end
      prev = cur;
      if (n > FRAME_CYCLES + 10)
        note_timeout("a sync edge");
    end
  endtask

  task automatic sync_test();
    int period;
    test_errors = 0;
    repeat (3) begin
      measure_period(1'b0, period);
      check_value("hsync period", period, H_TOTAL);
    end
    repeat (2) begin
      measure_period(1'b1, period);
      check_value("vsync period", period, FRAME_CYCLES);
    end
    report_test("sync");
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    host_req   = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    timed_out  = 0;
    seed_init  = $urandom(32'h44d13720);
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    if (!timed_out) single_sprites_test();
    if (!timed_out) overlap_test();
    if (!timed_out) slot_limit_test();
    if (!timed_out) playfield_test();
    if (!timed_out) handshake_test();
    if (!timed_out) sync_test();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0 && !timed_out)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/sprite_pkg.sv
verilog/beam_if.sv
verilog/video_timing.sv
verilog/sprite_table.sv
verilog/sprite_shape_rom.sv
verilog/sprite_line_renderer.sv
verilog/playfield_gen.sv
verilog/pixel_mixer.sv
verilog/sprite_video_top.sv
dv/sprite_video_tb.sv

// ==== verilog/beam_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// raster position shared by every block that follows the beam
interface beam_if;
  logic [8:0] hpos;
  logic [8:0] vpos;
  logic       hsync;      // active high
  logic       vsync;      // active high
  logic       display_on; // inside the 256x240 area

  modport source (output hpos, vpos, hsync, vsync, display_on);
  modport sink   (input  hpos, vpos, hsync, vsync, display_on);
endinterface

`default_nettype wire

// ==== verilog/pixel_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer
  import sprite_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  beam_if.sink       beam,
  input  color_t     sprite_color,
  input  color_t     field_color,
  output logic [3:0] rgb,
  output logic       hsync,
  output logic       vsync
);

  logic   disp_d1;  // beam flags one clock back, in step with the colours
  logic   hsync_d1;
  logic   vsync_d1;
  color_t pixel;

  // opaque sprite pixel beats the playfield
  assign pixel = (sprite_color != 4'd0) ? sprite_color : field_color;

  always_ff @(posedge clk) begin
    if (reset) begin
      disp_d1  <= 1'b0;
      hsync_d1 <= 1'b0;
      vsync_d1 <= 1'b0;
      rgb      <= '0;
      hsync    <= 1'b0;
      vsync    <= 1'b0;
    end else begin
      disp_d1  <= beam.display_on;
      hsync_d1 <= beam.hsync;
      vsync_d1 <= beam.vsync;
      rgb      <= disp_d1 ? pixel : 4'd0; // blank outside 256x240
      hsync    <= hsync_d1;               // 2 clocks behind the beam in all
      vsync    <= vsync_d1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/playfield_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module playfield_gen
  import sprite_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  beam_if.sink   beam,
  output color_t field_color
);

  logic on_grid; // every 32nd column or row

  assign on_grid = (beam.hpos[4:0] == 5'd0) || (beam.vpos[4:0] == 5'd0);

  // one clock late, same as sprite_color
  always_ff @(posedge clk) begin
    if (reset)
      field_color <= '0;
    else
      field_color <= on_grid ? GRID_COLOR : FIELD_COLOR;
  end

endmodule

`default_nettype wire

// ==== verilog/sprite_line_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_line_renderer
  import sprite_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  beam_if.sink        beam,
  output logic [5:0]  table_addr,
  input  logic [15:0] table_data,
  output logic        load_busy,
  output logic [5:0]  rom_addr,
  input  logic [15:0] rom_data,
  output color_t      sprite_color
);

  // frame copy of the sprite table
  logic [7:0] spr_xpos  [SPRITE_COUNT];
  logic [7:0] spr_ypos  [SPRITE_COUNT];
  logic [1:0] spr_shape [SPRITE_COUNT];
  color_t     spr_color [SPRITE_COUNT];
  logic       table_loaded;   // nothing drawn until the first copy

  logic         load_line;
  logic         load_valid;   // table_data holds word load_idx
  logic [5:0]   load_idx;
  sprite_word_u table_word;

  // line selection
  logic [SPRITE_BITS-1:0] sel_index;
  logic [8:0]             sel_yofs;   // vpos - ypos of sel_index, negative reads as large
  logic                   sel_take;
  logic [SLOT_BITS:0]     slot_count; // msb set once all slots are full
  logic [SPRITE_BITS-1:0] slot_sprite [SLOT_COUNT];
  logic [3:0]             slot_yofs   [SLOT_COUNT];
  logic [SLOT_COUNT-1:0]  slot_active;

  // slot drawing
  logic                   draw_line;
  logic                   rnd_on;
  logic [4:0]             rnd_phase;  // 0..23 within a slot
  logic [SLOT_BITS-1:0]   rnd_slot;
  logic [SPRITE_BITS-1:0] cur_sprite;
  logic [3:0]             cur_yofs;
  logic                   cur_on;
  logic [8:0]             wr_x;       // bit 8 set past the right edge
  logic [15:0]            out_bitmap;
  color_t                 out_color;
  logic                   pix_write;

  color_t     line_buf [512]; // two 256-pixel halves picked by vpos[0]
  logic [8:0] rd_idx;
  logic [8:0] wr_idx;

  assign load_line  = (beam.vpos == LOAD_LINE);
  assign load_busy  = load_line && (beam.hpos < LOAD_CYCLES);
  assign table_addr = beam.hpos[5:0];  // only meaningful in the load window
  assign table_word = table_data;

  // lines 256 and up never draw, so line 0 stays empty
  assign draw_line = !beam.vpos[8] && table_loaded;
  assign sel_index = beam.hpos[SPRITE_BITS:1]; // 2 clocks per sprite
  assign sel_take  = draw_line && (beam.hpos < SELECT_END) && beam.hpos[0]
                     && (sel_yofs < 9'(SPRITE_SIZE)) && !slot_count[SLOT_BITS];
  assign rnd_on    = draw_line && (beam.hpos >= SELECT_END) && (beam.hpos < RENDER_END);

  assign pix_write = rnd_on && (rnd_phase >= 5'(SLOT_SETUP)) && out_bitmap[0] && !wr_x[8];
  assign wr_idx    = {~beam.vpos[0], wr_x[7:0]}; // back half feeds line v+1
  assign rd_idx    = {beam.vpos[0], beam.hpos[7:0]};

  always_ff @(posedge clk) begin
    if (reset) begin
      load_valid   <= 1'b0;
      table_loaded <= 1'b0;
      slot_count   <= '0;
      slot_active  <= '0;
      rnd_phase    <= '0;
      rnd_slot     <= '0;
    end else begin
      load_valid <= load_line && (beam.hpos < SELECT_END); // 64 words
      if (load_valid && load_idx == 6'd63)
        table_loaded <= 1'b1;
      if (draw_line && beam.hpos == 9'd0) begin
        slot_count  <= '0;  // fresh slot list every line
        slot_active <= '0;
      end else if (sel_take) begin
        slot_active[slot_count[SLOT_BITS-1:0]] <= 1'b1;
        slot_count <= slot_count + 1'b1;
      end
      if (beam.hpos == SELECT_END - 9'd1) begin
        rnd_phase <= '0;
        rnd_slot  <= '0;
      end else if (rnd_on) begin
        if (rnd_phase == 5'(SLOT_CYCLES - 1)) begin
          rnd_phase <= '0;
          rnd_slot  <= rnd_slot + 1'b1;
        end else begin
          rnd_phase <= rnd_phase + 5'd1;
        end
      end
    end
  end

  // copy the table, even words hold position and odd words the attributes
  always_ff @(posedge clk) begin
    load_idx <= table_addr;
    if (load_valid) begin
      if (!load_idx[0]) begin
        spr_xpos[load_idx[5:1]] <= table_word.pos.xpos;
        spr_ypos[load_idx[5:1]] <= table_word.pos.ypos;
      end else begin
        spr_shape[load_idx[5:1]] <= table_word.attr.shape;
        spr_color[load_idx[5:1]] <= table_word.attr.color;
      end
    end
  end

  always_ff @(posedge clk) begin
    sel_yofs <= beam.vpos - {1'b0, spr_ypos[sel_index]}; // even clock, checked on the odd one
    if (sel_take) begin
      slot_sprite[slot_count[SLOT_BITS-1:0]] <= sel_index;
      slot_yofs[slot_count[SLOT_BITS-1:0]]   <= sel_yofs[3:0];
    end
  end

  // 8 setup clocks then 16 pixels per slot
  always_ff @(posedge clk) begin
    if (rnd_on) begin
      if (rnd_phase < 5'(SLOT_SETUP)) begin
        case (rnd_phase[2:0])
          3'd0: begin
            cur_sprite <= slot_sprite[rnd_slot];
            cur_yofs   <= slot_yofs[rnd_slot];
            cur_on     <= slot_active[rnd_slot];
          end
          3'd1: begin
            wr_x     <= {1'b0, spr_xpos[cur_sprite]};
            rom_addr <= {spr_shape[cur_sprite], cur_yofs};
          end
          3'd2: begin
            out_bitmap <= cur_on ? rom_data : 16'h0000; // empty slot draws nothing
            out_color  <= spr_color[cur_sprite];
          end
          default: ;
        endcase
      end else begin
        out_bitmap <= out_bitmap >> 1; // next pixel to the right
        wr_x       <= wr_x + 9'd1;
      end
    end
  end

  // front half is read and cleared behind the beam, back half takes the slots
  always_ff @(posedge clk) begin
    sprite_color     <= line_buf[rd_idx];
    line_buf[rd_idx] <= '0;
    if (pix_write)
      line_buf[wr_idx] <= out_color; // later slot overwrites
  end

endmodule

`default_nettype wire

// ==== verilog/sprite_pkg.sv ====
`default_nettype none

package sprite_pkg;

  // horizontal timing in clocks
  localparam logic [8:0] H_DISPLAY    = 9'd256;
  localparam logic [8:0] H_TOTAL      = 9'd309;
  localparam logic [8:0] H_SYNC_START = 9'd280;
  localparam logic [8:0] H_SYNC_END   = 9'd303; // first hpos after the pulse

  // vertical timing in lines
  localparam logic [8:0] V_DISPLAY    = 9'd240;
  localparam logic [8:0] V_TOTAL      = 9'd262;
  localparam logic [8:0] V_SYNC_START = 9'd244;
  localparam logic [8:0] V_SYNC_END   = 9'd247;

  localparam logic [8:0] LOAD_LINE    = 9'd260; // table copy happens here once per frame

  // sprite limits
  localparam int SPRITE_BITS  = 5;
  localparam int SPRITE_COUNT = 1 << SPRITE_BITS;
  localparam int SLOT_BITS    = 3;
  localparam int SLOT_COUNT   = 1 << SLOT_BITS; // sprites per line
  localparam int SPRITE_SIZE  = 16;

  // renderer schedule within a line
  localparam logic [8:0] SELECT_END  = 9'(2 * SPRITE_COUNT);      // 2 clocks per sprite
  localparam logic [8:0] LOAD_CYCLES = 9'(2 * SPRITE_COUNT + 8);
  localparam int         SLOT_SETUP  = 8;
  localparam int         SLOT_CYCLES = SLOT_SETUP + SPRITE_SIZE;  // 24 per slot
  localparam logic [8:0] RENDER_END  = 9'(2 * SPRITE_COUNT + SLOT_COUNT * SLOT_CYCLES);

  typedef logic [3:0] color_t; // 0 is transparent for sprites

  typedef struct packed {
    logic [7:0] ypos;
    logic [7:0] xpos;
  } sprite_pos_t; // table word 0

  typedef struct packed {
    logic [9:0] reserved;
    logic [1:0] shape;
    color_t     color;
  } sprite_attr_t; // table word 1

  typedef union packed {
    sprite_pos_t  pos;
    sprite_attr_t attr;
  } sprite_word_u;

  localparam color_t GRID_COLOR  = 4'd8;
  localparam color_t FIELD_COLOR = 4'd1;

endpackage

`default_nettype wire

// ==== verilog/sprite_shape_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_shape_rom (
  input  logic [5:0]  rom_addr, // {shape, row}
  output logic [15:0] rom_data  // bit 0 is the leftmost pixel
);

  logic [1:0] shape;
  logic [3:0] row;
  logic [15:0] figure_row;

  assign shape = rom_addr[5:4];
  assign row   = rom_addr[3:0];

  // little round figure, symmetric so bit order doesn't show
  always_comb begin
    case (row)
      4'h0: figure_row = 16'h07e0;
      4'h1: figure_row = 16'h1ff8;
      4'h2: figure_row = 16'h3ffc;
      4'h3: figure_row = 16'h799e;   // eyes
      4'h4: figure_row = 16'h799e;
      4'h5: figure_row = 16'h7ffe;
      4'h6: figure_row = 16'h7ffe;
      4'h7: figure_row = 16'h6ff6;
      4'h8: figure_row = 16'h77ee;   // mouth
      4'h9: figure_row = 16'h3c3c;
      4'ha: figure_row = 16'h1ff8;
      4'hb: figure_row = 16'h07e0;
      4'hc: figure_row = 16'h0180;   // neck
      4'hd: figure_row = 16'h0ff0;
      4'he: figure_row = 16'h0990;
      default: figure_row = 16'h1818; // feet
    endcase
  end

  always_comb begin
    case (shape)
      2'd0: rom_data = figure_row;
      2'd1: rom_data = 16'hffff;                                        // solid
      2'd2: rom_data = (row == 4'd0 || row == 4'd15) ? 16'hffff : 16'h8001; // frame
      default: rom_data = 16'h0001 << row;                              // diagonal
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/sprite_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_table (
  input  logic        clk,
  input  logic        reset,
  // host side, four-phase req/ack
  input  logic        host_req,
  input  logic [5:0]  host_addr,  // {sprite, word}
  input  logic [15:0] host_wdata,
  output logic        host_ack,
  // renderer side
  input  logic        load_busy,
  input  logic [5:0]  table_addr,
  output logic [15:0] table_data
);

  logic [15:0] mem [64]; // 2 words per sprite
  logic        host_write;

  // new request only while ack is low, and never during the frame load
  // so the renderer sees either the old or the new word, not a mix
  assign host_write = host_req && !host_ack && !load_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      host_ack <= 1'b0;
    end else if (host_write) begin
      host_ack <= 1'b1;                // same edge as the write
    end else if (!host_req) begin
      host_ack <= 1'b0;                // release once req has dropped
    end
  end

  always_ff @(posedge clk) begin
    if (host_write) begin
      mem[host_addr] <= host_wdata;
    end
    table_data <= mem[table_addr];     // registered read, 1 clock
  end

endmodule

`default_nettype wire

// ==== verilog/sprite_video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_video_top
  import sprite_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        host_req,
  input  logic [5:0]  host_addr,
  input  logic [15:0] host_wdata,
  output logic        host_ack,
  output logic [3:0]  rgb,
  output logic        hsync,
  output logic        vsync
);

  beam_if beam ();

  logic [5:0]  table_addr;
  logic [15:0] table_data;
  logic        load_busy;   // blocks host writes during the frame copy
  logic [5:0]  rom_addr;
  logic [15:0] rom_data;
  color_t      sprite_color;
  color_t      field_color;

  video_timing video_timing_inst (
    .clk   (clk),
    .reset (reset),
    .beam  (beam.source)
  );

  sprite_table sprite_table_inst (
    .clk        (clk),
    .reset      (reset),
    .host_req   (host_req),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .load_busy  (load_busy),
    .table_addr (table_addr),
    .table_data (table_data)
  );

  sprite_shape_rom sprite_shape_rom_inst (
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  sprite_line_renderer sprite_line_renderer_inst (
    .clk          (clk),
    .reset        (reset),
    .beam         (beam.sink),
    .table_addr   (table_addr),
    .table_data   (table_data),
    .load_busy    (load_busy),
    .rom_addr     (rom_addr),
    .rom_data     (rom_data),
    .sprite_color (sprite_color)
  );

  playfield_gen playfield_gen_inst (
    .clk         (clk),
    .reset       (reset),
    .beam        (beam.sink),
    .field_color (field_color)
  );

  pixel_mixer pixel_mixer_inst (
    .clk          (clk),
    .reset        (reset),
    .beam         (beam.sink),
    .sprite_color (sprite_color),
    .field_color  (field_color),
    .rgb          (rgb),
    .hsync        (hsync),
    .vsync        (vsync)
  );

endmodule

`default_nettype wire

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing
  import sprite_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  beam_if.source beam
);

  logic [8:0] hcount;
  logic [8:0] vcount;
  logic       hwrap; // last clock of the line

  assign hwrap = (hcount == H_TOTAL - 9'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      hcount <= '0;
      vcount <= '0;
    end else begin
      hcount <= hwrap ? 9'd0 : hcount + 9'd1;
      if (hwrap) begin
        // line counter steps once per line
        vcount <= (vcount == V_TOTAL - 9'd1) ? 9'd0 : vcount + 9'd1;
      end
    end
  end

  assign beam.hpos = hcount;
  assign beam.vpos = vcount;

  // syncs follow the counters directly, inactive at 0,0
  assign beam.hsync      = (hcount >= H_SYNC_START) && (hcount < H_SYNC_END);
  assign beam.vsync      = (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);
  assign beam.display_on = (hcount < H_DISPLAY) && (vcount < V_DISPLAY);

endmodule

`default_nettype wire
